// ==== design/link_fifo.sv ====
`default_nettype none

module link_fifo #(
  parameter int  depth_p   = 4,
  parameter type payload_t = logic
) (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            in_v_i,
  input  wire payload_t  in_data_i,
  output logic           in_ready_o,
  output logic           out_v_o,
  output payload_t       out_data_o,
  input  wire            out_ready_i
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_r [depth_p];  // storage, no reset.
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;
  logic                    pop;

  assign in_ready_o = (count_r != cnt_width_lp'(depth_p));  // count only, never valid.
  assign out_v_o    = (count_r != '0);
  assign out_data_o = mem_r[rd_ptr_r];
  assign push       = in_v_i && in_ready_o;
  assign pop        = out_v_o && out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // idle or push and pop together.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= in_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_endpoint.sv ====
`default_nettype none

module mem_endpoint #(
  parameter int mem_words_p  = 256,
  parameter int fifo_depth_p = 4
) (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  input  wire [mesh_pkg::cord_width-1:0] my_x_i,
  input  wire [mesh_pkg::cord_width-1:0] my_y_i,
  input  wire                            req_v_i,
  input  wire mesh_pkg::packet_t         req_data_i,
  output logic                           req_ready_o,
  output logic                           rsp_v_o,
  output mesh_pkg::packet_t              rsp_data_o,
  input  wire                            rsp_ready_i
);

  localparam int mem_addr_width_lp = $clog2(mem_words_p);

  logic [mesh_pkg::data_width-1:0] mem_r [mem_words_p];  // local data memory.
  logic [mem_addr_width_lp-1:0]    mem_addr;
  logic                            is_store;
  logic                            is_load;
  logic                            req_fire;
  logic                            load_v;
  mesh_pkg::reply_t                load_reply;
  mesh_pkg::reply_t                reply_head;

  assign mem_addr = req_data_i.addr[mem_addr_width_lp-1:0];
  assign is_store = (req_data_i.op == mesh_pkg::op_store);
  assign is_load  = (req_data_i.op == mesh_pkg::op_load);
  assign req_fire = req_v_i && req_ready_o;
  assign load_v   = req_v_i && is_load;

  // incoming replies are accepted like any request and simply dropped.
  always_ff @(posedge clk_i) begin
    if (req_fire && is_store) begin
      mem_r[mem_addr] <= req_data_i.data;
    end
  end

  // read is combinational, the reply is queued on the accepting edge.
  always_comb begin
    load_reply.req_x = req_data_i.src_x;
    load_reply.req_y = req_data_i.src_y;
    load_reply.data  = mem_r[mem_addr];
  end

  link_fifo #(
    .depth_p   (fifo_depth_p),
    .payload_t (mesh_pkg::reply_t)
  ) reply_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_v_i      (load_v),
    .in_data_i   (load_reply),
    .in_ready_o  (req_ready_o),  // all requests stall while replies are full.
    .out_v_o     (rsp_v_o),
    .out_data_o  (reply_head),
    .out_ready_i (rsp_ready_i)
  );

  // reply queue head as a network packet.
  always_comb begin
    rsp_data_o       = '0;
    rsp_data_o.op    = mesh_pkg::op_reply;
    rsp_data_o.dst_x = reply_head.req_x;
    rsp_data_o.dst_y = reply_head.req_y;
    rsp_data_o.src_x = my_x_i;
    rsp_data_o.src_y = my_y_i;
    rsp_data_o.addr  = '0;
    rsp_data_o.data  = reply_head.data;
  end

endmodule

`default_nettype wire

// ==== design/mesh_pkg.sv ====
`default_nettype none

package mesh_pkg;

  // router port indices, local port first.
  localparam logic [2:0] dir_p = 3'd0;
  localparam logic [2:0] dir_w = 3'd1;
  localparam logic [2:0] dir_e = 3'd2;
  localparam logic [2:0] dir_n = 3'd3;
  localparam logic [2:0] dir_s = 3'd4;

  localparam int num_dirs  = 4;  // neighbour links.
  localparam int num_ports = 5;  // neighbour links plus the local port.

  localparam int cord_width = 4;  // one x or y coordinate.
  localparam int addr_width = 8;  // endpoint word address.
  localparam int data_width = 32;

  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_reply = 2'd2
  } op_e;

  // 58 bits on every link.
  typedef struct packed {
    op_e                   op;
    logic [cord_width-1:0] dst_x;
    logic [cord_width-1:0] dst_y;
    logic [cord_width-1:0] src_x;
    logic [cord_width-1:0] src_y;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } packet_t;

  // load reply waiting to be sent back, 40 bits.
  typedef struct packed {
    logic [cord_width-1:0] req_x;
    logic [cord_width-1:0] req_y;
    logic [data_width-1:0] data;
  } reply_t;

endpackage

`default_nettype wire

// ==== design/mesh_router.sv ====
`default_nettype none

module mesh_router #(
  parameter int fifo_depth_p = 4
) (
  input  wire                                                    clk_i,
  input  wire                                                    arst_n_i,
  input  wire [mesh_pkg::cord_width-1:0]                         my_x_i,
  input  wire [mesh_pkg::cord_width-1:0]                         my_y_i,
  input  wire [mesh_pkg::dir_s:mesh_pkg::dir_w]                  link_v_i,
  input  wire mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w] link_data_i,
  output logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                 link_ready_o,
  output logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                 link_v_o,
  output mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w]    link_data_o,
  input  wire [mesh_pkg::dir_s:mesh_pkg::dir_w]                  link_ready_i,
  input  wire                                                    proc_v_i,
  input  wire mesh_pkg::packet_t                                 proc_data_i,
  output logic                                                   proc_ready_o,
  output logic                                                   proc_v_o,
  output mesh_pkg::packet_t                                      proc_data_o,
  input  wire                                                    proc_ready_i
);

  localparam int sel_width_lp = $clog2(mesh_pkg::num_ports);

  logic [mesh_pkg::num_ports-1:0]              in_v;
  mesh_pkg::packet_t [mesh_pkg::num_ports-1:0] in_data;
  logic [mesh_pkg::num_ports-1:0]              in_ready;
  logic [mesh_pkg::num_ports-1:0]              head_v;
  mesh_pkg::packet_t [mesh_pkg::num_ports-1:0] head_data;
  logic [mesh_pkg::num_ports-1:0]              head_pop;
  logic [sel_width_lp-1:0]                     route [mesh_pkg::num_ports];
  logic [mesh_pkg::num_ports-1:0]              out_v;
  mesh_pkg::packet_t [mesh_pkg::num_ports-1:0] out_data;
  logic [mesh_pkg::num_ports-1:0]              out_ready;
  logic [mesh_pkg::num_ports-1:0]              grant_v;
  logic [sel_width_lp-1:0]                     grant_idx [mesh_pkg::num_ports];
  logic [mesh_pkg::num_ports-1:0]              hold_v_r;  // output stalled, keep its grant.
  logic [sel_width_lp-1:0]                     hold_idx_r [mesh_pkg::num_ports];
  logic [sel_width_lp-1:0]                     rr_ptr_r [mesh_pkg::num_ports];

  // port 0 is local, 1..4 are W, E, N, S.
  assign in_v      = {link_v_i, proc_v_i};
  assign in_data   = {link_data_i, proc_data_i};
  assign out_ready = {link_ready_i, proc_ready_i};

  assign link_ready_o = in_ready[mesh_pkg::dir_s:mesh_pkg::dir_w];
  assign proc_ready_o = in_ready[mesh_pkg::dir_p];
  assign link_v_o     = out_v[mesh_pkg::dir_s:mesh_pkg::dir_w];
  assign link_data_o  = out_data[mesh_pkg::dir_s:mesh_pkg::dir_w];
  assign proc_v_o     = out_v[mesh_pkg::dir_p];
  assign proc_data_o  = out_data[mesh_pkg::dir_p];

  for (genvar p = 0; p < mesh_pkg::num_ports; p++) begin : g_in
    link_fifo #(
      .depth_p   (fifo_depth_p),
      .payload_t (mesh_pkg::packet_t)
    ) fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_v_i      (in_v[p]),
      .in_data_i   (in_data[p]),
      .in_ready_o  (in_ready[p]),
      .out_v_o     (head_v[p]),
      .out_data_o  (head_data[p]),
      .out_ready_i (head_pop[p])
    );
  end

  // dimension order routing, x first then y.
  always_comb begin
    for (int p = 0; p < mesh_pkg::num_ports; p++) begin
      if (head_data[p].dst_x > my_x_i) begin
        route[p] = mesh_pkg::dir_e;
      end else if (head_data[p].dst_x < my_x_i) begin
        route[p] = mesh_pkg::dir_w;
      end else if (head_data[p].dst_y > my_y_i) begin
        route[p] = mesh_pkg::dir_s;  // y grows southward.
      end else if (head_data[p].dst_y < my_y_i) begin
        route[p] = mesh_pkg::dir_n;
      end else begin
        route[p] = mesh_pkg::dir_p;
      end
    end
  end

  // round-robin pick per output, lowest offset from the pointer wins.
  always_comb begin
    int cand;
    cand = 0;
    for (int o = 0; o < mesh_pkg::num_ports; o++) begin
      grant_v[o]   = 1'b0;
      grant_idx[o] = '0;
      if (hold_v_r[o]) begin
        grant_v[o]   = 1'b1;  // head is still there, it was not popped.
        grant_idx[o] = hold_idx_r[o];
      end else begin
        for (int k = mesh_pkg::num_ports - 1; k >= 0; k--) begin
          cand = int'(rr_ptr_r[o]) + k;
          if (cand >= mesh_pkg::num_ports) begin
            cand = cand - mesh_pkg::num_ports;
          end
          if (head_v[cand] && (route[cand] == sel_width_lp'(o))) begin
            grant_v[o]   = 1'b1;
            grant_idx[o] = sel_width_lp'(cand);
          end
        end
      end
      out_v[o]    = grant_v[o];
      out_data[o] = head_data[grant_idx[o]];
    end
  end

  // a head routes to one output only, so at most one grant pops it.
  always_comb begin
    head_pop = '0;
    for (int o = 0; o < mesh_pkg::num_ports; o++) begin
      if (grant_v[o] && out_ready[o]) begin
        head_pop[grant_idx[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int o = 0; o < mesh_pkg::num_ports; o++) begin
        rr_ptr_r[o]   <= mesh_pkg::dir_p;
        hold_v_r[o]   <= 1'b0;
        hold_idx_r[o] <= '0;
      end
    end else begin
      for (int o = 0; o < mesh_pkg::num_ports; o++) begin
        hold_v_r[o]   <= grant_v[o] && !out_ready[o];  // keeps valid and data stable.
        hold_idx_r[o] <= grant_idx[o];
        if (grant_v[o] && out_ready[o]) begin
          rr_ptr_r[o] <= (grant_idx[o] == sel_width_lp'(mesh_pkg::num_ports - 1)) ?
                         '0 : grant_idx[o] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/mesh_tile.sv ====
`default_nettype none

module mesh_tile #(
  parameter int fifo_depth_p = 4,
  parameter int mem_words_p  = 256
) (
  input  wire                                                    clk_i,
  input  wire                                                    arst_n_i,
  input  wire [mesh_pkg::cord_width-1:0]                         my_x_i,
  input  wire [mesh_pkg::cord_width-1:0]                         my_y_i,
  input  wire [mesh_pkg::dir_s:mesh_pkg::dir_w]                  link_v_i,
  input  wire mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w] link_data_i,
  output logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                 link_ready_o,
  output logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                 link_v_o,
  output mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w]    link_data_o,
  input  wire [mesh_pkg::dir_s:mesh_pkg::dir_w]                  link_ready_i
);

  logic              arst_n_r;  // tile-local reset.
  logic              proc_v;  // router to endpoint.
  mesh_pkg::packet_t proc_data;
  logic              proc_ready;
  logic              ep_v;  // endpoint to router.
  mesh_pkg::packet_t ep_data;
  logic              ep_ready;

  // asserts at once, releases on the next clock edge.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arst_n_r <= 1'b0;
    end else begin
      arst_n_r <= 1'b1;
    end
  end

  mesh_router #(
    .fifo_depth_p (fifo_depth_p)
  ) rtr (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_r),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i),
    .proc_v_i     (ep_v),
    .proc_data_i  (ep_data),
    .proc_ready_o (ep_ready),
    .proc_v_o     (proc_v),
    .proc_data_o  (proc_data),
    .proc_ready_i (proc_ready)
  );

  mem_endpoint #(
    .mem_words_p  (mem_words_p),
    .fifo_depth_p (fifo_depth_p)
  ) ep (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_r),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .req_v_i     (proc_v),
    .req_data_i  (proc_data),
    .req_ready_o (proc_ready),
    .rsp_v_o     (ep_v),
    .rsp_data_o  (ep_data),
    .rsp_ready_i (ep_ready)
  );

endmodule

`default_nettype wire

// ==== filelist.f ====
design/mesh_pkg.sv
design/link_fifo.sv
design/mesh_router.sv
design/mem_endpoint.sv
design/mesh_tile.sv
sim/tb_clock_gen.sv
sim/tb_mesh_tile.sv

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int period_p       = 40,
  parameter int reset_cycles_p = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge.
  initial begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_mesh_tile.sv ====
`default_nettype none

module tb_mesh_tile;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifo_depth    = 4;
  localparam int mem_words     = 256;
  localparam int tile_x        = 2;
  localparam int tile_y        = 2;
  localparam int max_cycles    = 4000;  // the six tests need a few hundred cycles.
  localparam int rx_wait_limit = 50;

  logic                                                  clk;
  logic                                                  arst_n;
  logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                link_v_i;
  mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w]   link_data_i;
  logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                link_ready_o;
  logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                link_v_o;
  mesh_pkg::packet_t [mesh_pkg::dir_s:mesh_pkg::dir_w]   link_data_o;
  logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                link_ready_i;
  logic [mesh_pkg::dir_s:mesh_pkg::dir_w]                rx_ready;  // applied at the next falling edge.

  mesh_pkg::packet_t tx_q [mesh_pkg::dir_s:mesh_pkg::dir_w][$];
  mesh_pkg::packet_t rx_q [mesh_pkg::dir_s:mesh_pkg::dir_w][$];
  int                rx_cyc_q [mesh_pkg::dir_s:mesh_pkg::dir_w][$];
  logic [31:0]       mem_model [mem_words];
  logic              seen_v;
  int                cycle_count = 0;
  int                errors = 0;
  int                pass_count = 0;
  int                fail_count = 0;

  tb_clock_gen #(
    .period_p       (40),
    .reset_cycles_p (16)
  ) clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mesh_tile #(
    .fifo_depth_p (fifo_depth),
    .mem_words_p  (mem_words)
  ) UUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .my_x_i       (4'(tile_x)),
    .my_y_i       (4'(tile_y)),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic mesh_pkg::packet_t make_pkt(input mesh_pkg::op_e op, input int dx,
                                                 input int dy, input int sx, input int sy,
                                                 input logic [7:0] addr, input logic [31:0] data);
    mesh_pkg::packet_t p;
    p.op    = op;
    p.dst_x = 4'(dx);
    p.dst_y = 4'(dy);
    p.src_x = 4'(sx);
    p.src_y = 4'(sy);
    p.addr  = addr;
    p.data  = data;
    return p;
  endfunction

  // x first, then y; y grows toward south.
  function automatic int expect_port(input int dx, input int dy);
    if (dx > tile_x) return int'(mesh_pkg::dir_e);
    if (dx < tile_x) return int'(mesh_pkg::dir_w);
    if (dy > tile_y) return int'(mesh_pkg::dir_s);
    if (dy < tile_y) return int'(mesh_pkg::dir_n);
    return int'(mesh_pkg::dir_p);
  endfunction

  // outputs depend on no input combinationally, so one falling edge covers drive and sample.
  task automatic cycle_step();
    @(negedge clk);
    link_ready_i = rx_ready;
    for (int d = mesh_pkg::dir_w; d <= mesh_pkg::dir_s; d++) begin
      if (tx_q[d].size() > 0) begin
        link_v_i[d]    = 1'b1;
        link_data_i[d] = tx_q[d][0];
      end else begin
        link_v_i[d] = 1'b0;
      end
      if (link_v_i[d] && link_ready_o[d]) begin
        void'(tx_q[d].pop_front());  // taken on the coming rising edge.
      end
      if (link_v_o[d]) begin
        seen_v = 1'b1;
        if (link_ready_i[d]) begin
          rx_q[d].push_back(link_data_o[d]);
          rx_cyc_q[d].push_back(cycle_count);
        end
      end
    end
  endtask

  task automatic clear_rx();
    for (int d = mesh_pkg::dir_w; d <= mesh_pkg::dir_s; d++) begin
      rx_q[d].delete();
      rx_cyc_q[d].delete();
    end
  endtask

  task automatic wait_for_rx(input int d, input int n, output bit ok);
    int waited;
    waited = 0;
    while (rx_q[d].size() < n && waited < rx_wait_limit) begin
      cycle_step();
      waited++;
    end
    ok = (rx_q[d].size() >= n);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%0d ns: %s", $time, msg);
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      errors++;
      $display("error: %0d ns %s expected %0h got %0h", $time, what, exp, got);
    end
  endtask

  task automatic check_pkt(input string what, input mesh_pkg::packet_t exp,
                           input mesh_pkg::packet_t got);
    assert (got === exp) else begin
      errors++;
      $display("error: %0d ns %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic close_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail, %0d errors", name, errors - err_before);
    end
  endtask

  task automatic reset_values_test();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_value("link_v_o in reset", 0, link_v_o);
    while (arst_n !== 1'b1) @(negedge clk);
    cycle_step();
    check_value("link_v_o", 0, link_v_o);
    check_value("link_ready_o", 4'hf, link_ready_o);
    close_test("reset values", err0);
  endtask

  task automatic route_one(input int in_port, input int dx, input int dy);
    mesh_pkg::packet_t p;
    int                out_port;
    int                total;
    bit                ok;
    p        = make_pkt(mesh_pkg::op_store, dx, dy, 7, 7, 8'($urandom), $urandom);
    out_port = expect_port(dx, dy);
    clear_rx();
    tx_q[in_port].push_back(p);
    wait_for_rx(out_port, 1, ok);
    assert (ok) else note_failure($sformatf("packet from port %0d to (%0d,%0d) never left at %0d",
                                            in_port, dx, dy, out_port));
    if (ok) check_pkt("link_data_o", p, rx_q[out_port][0]);
    repeat (3) cycle_step();
    total = 0;
    for (int d = mesh_pkg::dir_w; d <= mesh_pkg::dir_s; d++) total += rx_q[d].size();
    check_value("packets delivered", 1, total);
  endtask

  task automatic xy_routing_test();
    int err0;
    err0 = errors;
    route_one(mesh_pkg::dir_w, 4, 2);
    route_one(mesh_pkg::dir_e, 1, 5);  // x is resolved before y.
    route_one(mesh_pkg::dir_s, 2, 0);
    route_one(mesh_pkg::dir_n, 2, 7);
    route_one(mesh_pkg::dir_n, 3, 0);
    close_test("xy routing", err0);
  endtask

  task automatic store_load_test();
    int          err0;
    bit          ok;
    logic [7:0]  addrs [4];
    logic [31:0] data;
    err0  = errors;
    addrs = '{8'h00, 8'h21, 8'h7e, 8'hff};
    clear_rx();
    for (int i = 0; i < 4; i++) begin
      data                = $urandom;
      mem_model[addrs[i]] = data;
      tx_q[mesh_pkg::dir_w].push_back(make_pkt(mesh_pkg::op_store, tile_x, tile_y, 0, 2,
                                               addrs[i], data));
    end
    data                = $urandom;  // overwrite one word before it is read.
    mem_model[addrs[1]] = data;
    tx_q[mesh_pkg::dir_w].push_back(make_pkt(mesh_pkg::op_store, tile_x, tile_y, 0, 2,
                                             addrs[1], data));
    for (int i = 0; i < 4; i++) begin
      tx_q[mesh_pkg::dir_w].push_back(make_pkt(mesh_pkg::op_load, tile_x, tile_y, 0, 2,
                                               addrs[i], 32'h0));
    end
    wait_for_rx(mesh_pkg::dir_w, 4, ok);
    assert (ok) else note_failure("fewer than four load replies came back at W");
    for (int i = 0; i < 4 && i < rx_q[mesh_pkg::dir_w].size(); i++) begin
      check_pkt("load reply", make_pkt(mesh_pkg::op_reply, 0, 2, tile_x, tile_y, 8'h00,
                                       mem_model[addrs[i]]), rx_q[mesh_pkg::dir_w][i]);
    end
    close_test("store and load", err0);
  endtask

  task automatic backpressure_test();
    int                err0;
    int                waited;
    bit                ok;
    mesh_pkg::packet_t sent [6];
    err0 = errors;
    clear_rx();
    rx_ready[mesh_pkg::dir_e] = 1'b0;
    for (int i = 0; i < 6; i++) begin
      sent[i] = make_pkt(mesh_pkg::op_store, 4, 2, 0, 2, 8'(i), $urandom);
      tx_q[mesh_pkg::dir_w].push_back(sent[i]);
    end
    waited = 0;
    cycle_step();
    while (link_ready_o[mesh_pkg::dir_w] && waited < 20) begin
      cycle_step();
      waited++;
    end
    assert (!link_ready_o[mesh_pkg::dir_w]) else
      note_failure("link_ready_o[W] never dropped while E was stalled");
    check_value("packets accepted at W", fifo_depth, 6 - tx_q[mesh_pkg::dir_w].size());
    check_value("link_v_o[E] while stalled", 1, link_v_o[mesh_pkg::dir_e]);
    rx_ready[mesh_pkg::dir_e] = 1'b1;
    wait_for_rx(mesh_pkg::dir_e, 6, ok);
    assert (ok) else note_failure("packets were lost after E was released");
    for (int i = 0; i < 6 && i < rx_q[mesh_pkg::dir_e].size(); i++) begin
      check_pkt("link_data_o[E]", sent[i], rx_q[mesh_pkg::dir_e][i]);
    end
    close_test("back-pressure", err0);
  endtask

  task automatic contention_test();
    int                err0;
    bit                ok;
    mesh_pkg::packet_t a;
    mesh_pkg::packet_t b;
    err0 = errors;
    clear_rx();
    a = make_pkt(mesh_pkg::op_store, 4, 2, 2, 0, 8'h11, $urandom);
    b = make_pkt(mesh_pkg::op_store, 3, 1, 2, 5, 8'h22, $urandom);
    tx_q[mesh_pkg::dir_n].push_back(a);
    tx_q[mesh_pkg::dir_s].push_back(b);
    wait_for_rx(mesh_pkg::dir_e, 2, ok);
    assert (ok) else note_failure("both contending packets did not reach E");
    if (ok) begin
      assert ((rx_q[mesh_pkg::dir_e][0] === a && rx_q[mesh_pkg::dir_e][1] === b) ||
              (rx_q[mesh_pkg::dir_e][0] === b && rx_q[mesh_pkg::dir_e][1] === a)) else
        note_failure("packets at E do not match the two sent from N and S");
      check_value("cycles between deliveries", 1,
                  rx_cyc_q[mesh_pkg::dir_e][1] - rx_cyc_q[mesh_pkg::dir_e][0]);
    end
    close_test("contention", err0);
  endtask

  task automatic reply_sink_test();
    int err0;
    int waited;
    err0 = errors;
    clear_rx();
    tx_q[mesh_pkg::dir_w].push_back(make_pkt(mesh_pkg::op_reply, tile_x, tile_y, 0, 2, 8'h00,
                                             $urandom));
    seen_v = 1'b0;
    waited = 0;
    while (tx_q[mesh_pkg::dir_w].size() > 0 && waited < rx_wait_limit) begin
      cycle_step();
      waited++;
    end
    assert (tx_q[mesh_pkg::dir_w].size() == 0) else note_failure("reply packet was not accepted");
    repeat (10) cycle_step();
    assert (!seen_v) else note_failure("a link_v_o rose after a reply addressed to this tile");
    close_test("reply consumed", err0);
  endtask

  initial begin
    void'($urandom(64));
    link_v_i     = '0;
    link_data_i  = '0;
    link_ready_i = '1;
    rx_ready     = '1;
    seen_v       = 1'b0;
    reset_values_test();
    xy_routing_test();
    store_load_test();
    backpressure_test();
    contention_test();
    reply_sink_test();
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
